// File: signmag_unit_top.f
signmag_pkg.sv
signmag_conv_axis.sv
burst_ctrl_fsm.sv
beat_counter.sv
conv_apb_regs.sv
signmag_unit_top.sv
signmag_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module signmag_unit_tb \
    -f signmag_unit_top.f \
    -o signmag_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/signmag_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    echo "Testbench reported failure"
    exit 1
fi

echo "Run finished without failure"
exit 0

// File: signmag_unit_tb.sv
/* Testbench for the sign-magnitude converter subsystem
   APB setup, stream bursts with optional back-pressure, scoreboard by assertion */
`default_nettype none

module signmag_unit_tb;
    import signmag_pkg::*;

    localparam int LEN_A = 16;
    localparam int LEN_B = 12;
    localparam int LEN_C = 24;
    localparam int LEN_D = 8;
    localparam int TOTAL_BEATS = LEN_A + LEN_B + LEN_C + LEN_D;
    localparam int WATCHDOG = 200 * TOTAL_BEATS;
    localparam logic [31:0] SEED = 32'h2fd4_248d;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    conv_word_u  s_tdata;
    logic        s_tvalid;
    logic        s_tready;
    conv_word_u  m_tdata;
    logic        m_tvalid;
    logic        m_tready;

    logic        bp_en;
    logic        cur_mode;
    int          cur_len;
    int          burst_base;
    int          acc_total;
    int          exp_cnt;
    logic [15:0] exp_head;
    logic [15:0] prev_mdata;
    logic [15:0] exp_q[$];
    logic [15:0] words[$];
    int          data_errs;
    int          proto_errs;
    int          reg_errs;

    signmag_unit_top #(.CNT_W(16)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sink side, random stalls only when enabled
    initial begin
        m_tready = 1'b0;
        forever begin
            @(posedge clk);
            m_tready <= bp_en ? ($urandom % 32'd3 != 32'd0) : 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog expired after %0d cycles, burst never completed", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

    // Conversion rules, written from the format definitions
    function automatic logic [15:0] expect_word(input logic [15:0] w, input logic m);
        logic [15:0] abs_val;
        int          tc_val;
        if (!w[15]) begin
            return w;
        end
        if (!m) begin
            // Most negative value has no 15-bit magnitude
            if (w == 16'h8000) begin
                return 16'hFFFF;
            end
            abs_val = ~w + 16'd1;
            return {1'b1, abs_val[14:0]};
        end
        if (w[14:0] == 15'd0) begin
            return 16'h0000;
        end
        // Value is minus the magnitude
        tc_val = -int'(w[14:0]);
        return tc_val[15:0];
    endfunction

    // Expected outputs follow accepted inputs in order
    always @(posedge clk) begin
        if (s_tvalid && s_tready) begin
            exp_q.push_back(expect_word(s_tdata.tc, cur_mode));
            acc_total <= acc_total + 1;
        end
        if (m_tvalid && m_tready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_head   <= (exp_q.size() > 0) ? exp_q[0] : 16'h0000;
        exp_cnt    <= exp_q.size();
        prev_mdata <= m_tdata.tc;
    end

    a_data_match: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && m_tready |-> m_tdata.tc == exp_head)
        else begin
            data_errs++;
            $display("[FAIL] %0t m_tdata expected %h got %h",
                     $time, $sampled(exp_head), $sampled(m_tdata));
        end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid |-> exp_cnt != 0)
        else begin
            proto_errs++;
            $display("Output beat at %0t has no matching input beat", $time);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && m_tdata.tc == prev_mdata)
        else begin
            proto_errs++;
            $display("[FAIL] %0t m_tdata expected %h got %h",
                     $time, $sampled(prev_mdata), $sampled(m_tdata));
        end

    a_burst_bound: assert property (@(posedge clk) disable iff (!rst_n)
        s_tvalid && s_tready |-> (acc_total - burst_base) < cur_len)
        else begin
            proto_errs++;
            $display("Beat accepted past the burst length at %0t", $time);
        end

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        if (!apb_rsp.pready) begin
            reg_errs++;
            $display("[FAIL] %0t pready expected 1 got %b", $time, apb_rsp.pready);
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic check_reg(input string name, input logic [3:0] addr,
                             input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_read(addr, rd, err);
        assert (rd == exp && !err) else begin
            reg_errs++;
            $display("[FAIL] %0t %s expected %h got %h (pslverr %b)", $time, name, exp, rd, err);
        end
    endtask

    // Called just after a rising edge, returns just after the handshake edge
    task automatic send_word(input logic [15:0] w);
        s_tdata  <= w;
        s_tvalid <= 1'b1;
        @(negedge clk);
        while (!s_tready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic add_random(input int n);
        repeat (n) words.push_back(16'($urandom));
    endtask

    task automatic run_burst(input logic mode_sel, input logic bp, input logic mode_poke);
        int          len;
        logic [31:0] rd;
        logic        err;
        len = words.size();
        cur_mode   <= mode_sel;
        cur_len    <= len;
        burst_base <= acc_total;
        bp_en      <= bp;
        apb_write(REG_LEN, 32'(len));
        apb_write(REG_CTRL, 32'({mode_sel, 1'b1}));
        foreach (words[i]) begin
            if (mode_poke && i == len / 2) begin
                // Flip the mode mid-burst, the DUT must keep the old one
                s_tvalid <= 1'b0;
                apb_write(REG_CTRL, 32'({~mode_sel, 1'b0}));
            end
            send_word(words[i]);
        end
        // Keep offering a stray word while the burst drains
        s_tdata <= 16'h1234;
        do begin
            apb_read(REG_STATUS, rd, err);
        end while (!rd[STATUS_DONE_BIT]);
        s_tvalid <= 1'b0;
        bp_en    <= 1'b0;
        check_reg("STATUS", REG_STATUS, 32'h2);
        check_reg("COUNT", REG_COUNT, 32'(len));
        assert (exp_cnt == 0) else begin
            data_errs++;
            $display("[FAIL] %0t pending outputs expected 0 got %0d", $time, exp_cnt);
        end
        apb_write(REG_STATUS, 32'h2);
        check_reg("STATUS", REG_STATUS, 32'h0);
        words.delete();
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        apb_req    = '0;
        s_tdata    = '0;
        s_tvalid   = 1'b0;
        rst_n      = 1'b0;
        bp_en      = 1'b0;
        cur_mode   = 1'b0;
        cur_len    = 0;
        burst_base = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!m_tvalid && !s_tready) else begin
            proto_errs++;
            $display("[FAIL] %0t m_tvalid/s_tready expected 0/0 got %b/%b",
                     $time, m_tvalid, s_tready);
        end
        check_reg("STATUS", REG_STATUS, 32'h0);
        check_reg("LEN", REG_LEN, 32'h0);
        check_reg("CTRL", REG_CTRL, 32'h0);

        apb_read(4'h2, rd, err);
        assert (err && rd == 32'h0) else begin
            reg_errs++;
            $display("[FAIL] %0t unmapped prdata/pslverr expected 00000000/1 got %h/%b",
                     $time, rd, err);
        end

        words = '{16'h0000, 16'h7FFF, 16'hFFFF, 16'h8000};
        add_random(LEN_A - 4);
        run_burst(1'b0, 1'b0, 1'b0);

        words = '{16'h8000, 16'h0000};
        add_random(LEN_B - 2);
        run_burst(1'b1, 1'b0, 1'b0);

        add_random(LEN_C);
        run_burst(1'b0, 1'b1, 1'b0);

        add_random(LEN_D - 1);
        // Negative zero after the mode poke tells the two modes apart
        words.push_back(16'h8000);
        run_burst(1'b1, 1'b0, 1'b1);

        $display("Errors: data %0d, protocol %0d, register %0d",
                 data_errs, proto_errs, reg_errs);
        if (data_errs + proto_errs + reg_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: signmag_unit_top.sv
/* Converter subsystem top level
   APB registers, burst FSM, beat counter and stream pipeline */
`default_nettype none

module signmag_unit_top #(
    parameter int CNT_W = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  signmag_pkg::apb_req_t   apb_req,
    output signmag_pkg::apb_rsp_t   apb_rsp,
    input  signmag_pkg::conv_word_u s_tdata,
    input  logic                    s_tvalid,
    output logic                    s_tready,
    output signmag_pkg::conv_word_u m_tdata,
    output logic                    m_tvalid,
    input  logic                    m_tready
);

    logic             start_pulse;
    logic             mode;
    logic [CNT_W-1:0] burst_len;
    logic [CNT_W-1:0] count;
    logic             busy;
    logic             done_set;
    logic             last_beat;
    logic             accept_en;
    logic             count_clr;
    logic             pipe_empty;
    logic             beat;

    // Counted beats are exactly the input handshakes
    assign beat = s_tvalid && s_tready;

    conv_apb_regs #(.CNT_W(CNT_W)) regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .busy        (busy),
        .done_set    (done_set),
        .count       (count),
        .start_pulse (start_pulse),
        .mode        (mode),
        .burst_len   (burst_len)
    );

    burst_ctrl_fsm fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .last_beat   (last_beat),
        .pipe_empty  (pipe_empty),
        .accept_en   (accept_en),
        .count_clr   (count_clr),
        .busy        (busy),
        .done_set    (done_set)
    );

    beat_counter #(.CNT_W(CNT_W)) cnt_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (count_clr),
        .beat      (beat),
        .burst_len (burst_len),
        .count     (count),
        .last_beat (last_beat)
    );

    signmag_conv_axis conv_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept_en (accept_en),
        .mode      (mode),
        .s_tdata   (s_tdata),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .m_tdata   (m_tdata),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .empty     (pipe_empty)
    );

endmodule

`default_nettype wire

// File: conv_apb_regs.sv
/* APB register block for the converter
   Control, burst length, sticky status and beat count */
`default_nettype none

module conv_apb_regs #(
    parameter int CNT_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  signmag_pkg::apb_req_t apb_req,
    output signmag_pkg::apb_rsp_t apb_rsp,
    input  logic                  busy,
    input  logic                  done_set,
    input  logic [CNT_W-1:0]      count,
    output logic                  start_pulse,
    output logic                  mode,
    output logic [CNT_W-1:0]      burst_len
);
    import signmag_pkg::*;

    logic        access;
    logic        addr_ok;
    logic        wr_en;
    logic        done_q;
    logic [31:0] rdata;

    assign access  = apb_req.psel && apb_req.penable;
    assign addr_ok = (apb_req.paddr == REG_CTRL) || (apb_req.paddr == REG_LEN) ||
                     (apb_req.paddr == REG_STATUS) || (apb_req.paddr == REG_COUNT);
    assign wr_en   = access && apb_req.pwrite && addr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pulse <= 1'b0;
            mode        <= 1'b0;
            burst_len   <= '0;
            done_q      <= 1'b0;
        end else begin
            start_pulse <= wr_en && (apb_req.paddr == REG_CTRL) &&
                           apb_req.pwdata[CTRL_START_BIT] && !busy;
            // Mode and length hold for the whole burst
            if (wr_en && !busy) begin
                if (apb_req.paddr == REG_CTRL) begin
                    mode <= apb_req.pwdata[CTRL_MODE_BIT];
                end
                if (apb_req.paddr == REG_LEN) begin
                    burst_len <= apb_req.pwdata[CNT_W-1:0];
                end
            end
            // Set beats a same-cycle clear
            if (done_set) begin
                done_q <= 1'b1;
            end else if (wr_en && (apb_req.paddr == REG_STATUS) &&
                         apb_req.pwdata[STATUS_DONE_BIT]) begin
                done_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            REG_CTRL:   rdata[CTRL_MODE_BIT] = mode;
            REG_LEN:    rdata[CNT_W-1:0] = burst_len;
            REG_STATUS: begin
                rdata[STATUS_BUSY_BIT] = busy;
                rdata[STATUS_DONE_BIT] = done_q;
            end
            REG_COUNT:  rdata[CNT_W-1:0] = count;
            default:    rdata = '0;
        endcase
    end

    // Zero wait states, unmapped offsets answer with an error
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !addr_ok;
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
    end

endmodule

`default_nettype wire

// File: beat_counter.sv
/* Accepted-beat counter with end-of-burst compare */
`default_nettype none

module beat_counter #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clr,
    input  logic             beat,
    input  logic [CNT_W-1:0] burst_len,
    output logic [CNT_W-1:0] count,
    output logic             last_beat
);

    logic [CNT_W-1:0] count_inc;

    assign count_inc = count + 1'b1;

    // Zero length ends the burst before any beat
    assign last_beat = (burst_len == '0) || (beat && (count_inc == burst_len));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clr) begin
            count <= '0;
        end else if (beat) begin
            count <= count_inc;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        beat && !clr |=> count <= burst_len)
        else $error("beat count ran past burst length");

endmodule

`default_nettype wire

// File: burst_ctrl_fsm.sv
/* Burst sequencer, idle to run to drain to done */
`default_nettype none

module burst_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start_pulse,
    input  logic last_beat,
    input  logic pipe_empty,
    output logic accept_en,
    output logic count_clr,
    output logic busy,
    output logic done_set
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // last_beat already high in IDLE means a zero-length burst
            IDLE:  if (start_pulse) state_nxt = last_beat ? DRAIN : RUN;
            RUN:   if (last_beat) state_nxt = DRAIN;
            DRAIN: if (pipe_empty) state_nxt = DONE;
            DONE:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign accept_en = (state == RUN);
    assign count_clr = (state == IDLE) && start_pulse;
    assign busy      = (state != IDLE);
    assign done_set  = (state == DONE);

    a_accept_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(accept_en) |-> $past(start_pulse))
        else $error("accept_en raised without a start pulse");

endmodule

`default_nettype wire

// File: signmag_conv_axis.sv
/* Three-stage two's complement / sign-magnitude converter
   AXI-Stream in and out, each stage stalls on its own */
`default_nettype none

module signmag_conv_axis (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept_en,
    input  logic                    mode,
    input  signmag_pkg::conv_word_u s_tdata,
    input  logic                    s_tvalid,
    output logic                    s_tready,
    output signmag_pkg::conv_word_u m_tdata,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    empty
);
    import signmag_pkg::*;

    conv_word_u        s1_data;
    logic              s1_mode;
    logic              s1_valid;
    conv_word_u        s2_data;
    logic              s2_valid;
    logic              s3_valid;
    conv_word_u        conv_word;
    logic [DATA_W-1:0] neg_tc;
    logic [DATA_W-1:0] neg_mag;
    logic              s1_load;
    logic              s2_load;
    logic              s3_load;

    // Load enables, back to front
    assign s3_load  = s2_valid && (!s3_valid || m_tready);
    assign s2_load  = s1_valid && (!s2_valid || s3_load);
    assign s_tready = accept_en && (!s1_valid || s2_load);
    assign s1_load  = s_tvalid && s_tready;

    assign m_tvalid = s3_valid;
    assign empty    = !s1_valid && !s2_valid && !s3_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid <= 1'b1;
            end else if (s2_load) begin
                s1_valid <= 1'b0;
            end
            if (s2_load) begin
                s2_valid <= 1'b1;
            end else if (s3_load) begin
                s2_valid <= 1'b0;
            end
            if (s3_load) begin
                s3_valid <= 1'b1;
            end else if (m_tready) begin
                s3_valid <= 1'b0;
            end
        end
    end

    // Mode travels with the word
    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_data <= s_tdata;
            s1_mode <= mode;
        end
        if (s2_load) begin
            s2_data <= conv_word;
        end
        if (s3_load) begin
            m_tdata <= s2_data;
        end
    end

    assign neg_tc  = -s1_data.tc;
    assign neg_mag = -{1'b0, s1_data.sm.mag};

    // Positive words pass unchanged in both modes
    always_comb begin
        conv_word = s1_data;
        if (s1_data.sm.sign) begin
            if (!s1_mode) begin
                if (s1_data.sm.mag == '0) begin
                    // -32768 has no magnitude, clamp to -7FFF
                    conv_word.tc = '1;
                end else begin
                    conv_word.sm.mag = neg_tc[DATA_W-2:0];
                end
            end else begin
                // Negative zero folds to plain zero
                if (s1_data.sm.mag == '0) begin
                    conv_word.tc = '0;
                end else begin
                    conv_word.tc = neg_mag;
                end
            end
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
        else $error("m_tdata changed while stalled");

    a_no_accept_off: assert property (@(posedge clk) disable iff (!rst_n)
        !accept_en && !s1_valid |=> !s1_valid)
        else $error("beat entered stage 1 with accept_en low");

endmodule

`default_nettype wire

// File: signmag_pkg.sv
/* Sign-magnitude converter shared types
   Word views, APB request and response structs, register map */
`default_nettype none

package signmag_pkg;

    // Stream word width, fixed by the union layout below
    localparam int DATA_W = 16;

    // Sign-magnitude view of one stream word
    typedef struct packed {
        logic              sign;
        logic [DATA_W-2:0] mag;
    } sm_word_t;

    // Same word read as two's complement or as sign-magnitude
    typedef union packed {
        logic [DATA_W-1:0] tc;
        sm_word_t          sm;
    } conv_word_u;

    // APB requester side, one slave select
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB completer side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register map
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_LEN    = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;
    localparam logic [3:0] REG_COUNT  = 4'hC;

    // CTRL and STATUS bit positions
    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_MODE_BIT   = 1;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire
